// File: source/ghtPkg.sv
// Global history table package.
// Table geometry, index field types and the clear-sweep state,
// plus helpers that split a 16-bit table index into its fields.

`default_nettype none

package ghtPkg;

    localparam int INDEX_BITS    = 16;
    localparam int NUM_BANKS     = 8;
    localparam int ROWS_PER_BANK = 32;
    localparam int BITS_PER_ROW  = 256;

    typedef logic [INDEX_BITS-1:0] ghtIndex_t;
    typedef logic [2:0] bankSel_t;
    typedef logic [4:0] rowAddr_t;
    typedef logic [7:0] bitSel_t;

    typedef enum logic {
        SWEEP_CLEAR,
        SWEEP_DONE
    } sweepState_t;

    // bank comes from bits 7, 6 and 0, in that order
    function automatic bankSel_t bankOf(ghtIndex_t idx);
        return {idx[7], idx[6], idx[0]};
    endfunction

    function automatic rowAddr_t rowOf(ghtIndex_t idx);
        return idx[5:1];
    endfunction

    function automatic bitSel_t bitOf(ghtIndex_t idx);
        return idx[15:8];
    endfunction

endpackage

`default_nettype wire

// File: source/ghtBankWriteIf.sv
// Bank write interface.
// One write request per cycle from the arbiter to a single bank,
// either a one-bit write or a whole-row clear.

`default_nettype none
`timescale 1ns/1ps

interface ghtBankWriteIf;
    import ghtPkg::*;

    logic     wen;
    logic     clear;
    rowAddr_t row;
    bitSel_t  bitSel;
    logic     val;

    // wen and clear never assert together
    modport arbiter (
        output wen, clear, row, bitSel, val
    );

    modport bank (
        input wen, clear, row, bitSel, val
    );

endinterface

`default_nettype wire

// File: source/ghtBank.sv
// Global history table bank.
// 32 rows of 256 one-bit entries. Writes are synchronous, either one
// bit or a whole row cleared to zero. The read is combinational, one
// bit picked from the addressed row in two select levels.

`default_nettype none
`timescale 1ns/1ps

module ghtBank (
    input  wire              clk,
    ghtBankWriteIf.bank      wr,
    input  ghtPkg::rowAddr_t rdRow,
    input  ghtPkg::bitSel_t  rdBitSel,
    output logic             rdBit
);
    import ghtPkg::*;

    localparam int GROUP_BITS = 16;
    localparam int NUM_GROUPS = BITS_PER_ROW / GROUP_BITS;

    logic [BITS_PER_ROW-1:0] mem [ROWS_PER_BANK];
    logic [BITS_PER_ROW-1:0] rowData;
    logic [NUM_GROUPS-1:0]   groupBits;

    always_ff @(posedge clk) begin
        if (wr.clear) begin
            mem[wr.row] <= '0;
        end else if (wr.wen) begin
            mem[wr.row][wr.bitSel] <= wr.val;
        end
    end

    assign rowData = mem[rdRow];

    // low nibble picks a bit inside each group of 16
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : groupSel
        logic [GROUP_BITS-1:0] grp;

        assign grp          = rowData[g*GROUP_BITS +: GROUP_BITS];
        assign groupBits[g] = grp[rdBitSel[3:0]];
    end

    // high nibble picks the group
    assign rdBit = groupBits[rdBitSel[7:4]];

endmodule

`default_nettype wire

// File: source/ghtLookup.sv
// Global history table lookup.
// Captures the instruction pointer XOR history as the table index when
// readEn is high, sends row and bit select to every bank and returns
// the answering bank's bit as the prediction.

`default_nettype none
`timescale 1ns/1ps

module ghtLookup (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       readEn,
    input  ghtPkg::ghtIndex_t         ipBits,
    input  ghtPkg::ghtIndex_t         history,
    input  wire [ghtPkg::NUM_BANKS-1:0] bankBits,
    output ghtPkg::rowAddr_t          rdRow,
    output ghtPkg::bitSel_t           rdBitSel,
    output logic                      predTaken
);
    import ghtPkg::*;

    ghtIndex_t idxReg;
    bankSel_t  rdBank;

    // index stays put until the next lookup
    always_ff @(posedge clk) begin
        if (rst) begin
            idxReg <= '0;
        end else if (readEn) begin
            idxReg <= ipBits ^ history;
        end
    end

    assign rdRow    = rowOf(idxReg);
    assign rdBitSel = bitOf(idxReg);
    assign rdBank   = bankOf(idxReg);

    // banks read asynchronously, so a landed write shows right away
    assign predTaken = bankBits[rdBank];

endmodule

`default_nettype wire

// File: source/ghtInitSweep.sv
// Global history table clear sweep.
// After reset, walks rows 0 to 31, one per cycle, so that every bank
// gets each row zeroed before updates are let through.

`default_nettype none
`timescale 1ns/1ps

module ghtInitSweep (
    input  wire              clk,
    input  wire              rst,
    output logic             clearing,
    output ghtPkg::rowAddr_t clearRow
);
    import ghtPkg::*;

    sweepState_t state;
    rowAddr_t    rowCnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= SWEEP_CLEAR;
            rowCnt <= '0;
        end else if (state == SWEEP_CLEAR) begin
            rowCnt <= rowCnt + 1'b1;
            if (rowCnt == rowAddr_t'(ROWS_PER_BANK - 1)) begin
                state <= SWEEP_DONE;
            end
        end
    end

    assign clearing = (state == SWEEP_CLEAR);
    assign clearRow = rowCnt;

endmodule

`default_nettype wire

// File: source/ghtWriteArbiter.sv
// Global history table write arbiter.
// Routes the two update ports and a one-entry save buffer to the eight
// banks, at most one write per bank per cycle. A bank conflict defers
// one write by a cycle through the buffer. During the clear sweep all
// banks get a row clear and updates are ignored.

`default_nettype none
`timescale 1ns/1ps

module ghtWriteArbiter (
    input  wire                clk,
    input  wire                rst,
    input  wire                write0Val,
    input  ghtPkg::ghtIndex_t  write0Index,
    input  wire                write0Wen,
    input  wire                write1Val,
    input  ghtPkg::ghtIndex_t  write1Index,
    input  wire                write1Wen,
    input  wire                clearing,
    input  ghtPkg::rowAddr_t   clearRow,
    ghtBankWriteIf.arbiter     bankWr [ghtPkg::NUM_BANKS]
);
    import ghtPkg::*;

    ghtIndex_t bufIndex;
    logic      bufVal;
    logic      bufFull;

    bankSel_t  bank0;
    bankSel_t  bank1;
    bankSel_t  bankS;

    logic      w0Ok;
    logic      w1Ok;
    logic      save0;
    logic      save1;

    assign bank0 = bankOf(write0Index);
    assign bank1 = bankOf(write1Index);
    assign bankS = bankOf(bufIndex);

    // buffered write always goes first
    assign w0Ok = write0Wen && !(bufFull && bank0 == bankS);
    assign w1Ok = write1Wen && !(bufFull && bank1 == bankS)
                  && !(write0Wen && bank1 == bank0);

    // write1 wins the buffer, so write0 drops if both are blocked
    assign save1 = write1Wen && !w1Ok;
    assign save0 = write0Wen && !w0Ok && !save1;

    always_ff @(posedge clk) begin
        if (rst || clearing) begin
            bufFull <= 1'b0;
        end else begin
            bufFull <= save1 || save0;
        end
    end

    always_ff @(posedge clk) begin
        if (save1) begin
            bufIndex <= write1Index;
            bufVal   <= write1Val;
        end else if (save0) begin
            bufIndex <= write0Index;
            bufVal   <= write0Val;
        end
    end

    for (genvar k = 0; k < NUM_BANKS; k++) begin : bankDrv
        logic      hitS;
        logic      hit0;
        logic      hit1;
        ghtIndex_t selIndex;
        logic      selVal;

        assign hitS = bufFull && bankS == bankSel_t'(k);
        assign hit0 = w0Ok && bank0 == bankSel_t'(k);
        assign hit1 = w1Ok && bank1 == bankSel_t'(k);

        // rules guarantee at most one hit per bank
        assign selIndex = hitS ? bufIndex : (hit0 ? write0Index : write1Index);
        assign selVal   = hitS ? bufVal : (hit0 ? write0Val : write1Val);

        assign bankWr[k].clear  = clearing;
        assign bankWr[k].wen    = !clearing && (hitS || hit0 || hit1);
        assign bankWr[k].row    = clearing ? clearRow : rowOf(selIndex);
        assign bankWr[k].bitSel = clearing ? '0 : bitOf(selIndex);
        assign bankWr[k].val    = !clearing && selVal;
    end

endmodule

`default_nettype wire

// File: source/ght.sv
// Global history table, top level.
// 65536 one-bit taken/not-taken entries over eight banks, one lookup
// port and two single-bit update ports. Cleared by a sweep after reset.

`default_nettype none
`timescale 1ns/1ps

module ght (
    input  wire               clk,
    input  wire               rst,
    input  wire               readEn,
    input  ghtPkg::ghtIndex_t ipBits,
    input  ghtPkg::ghtIndex_t history,
    input  wire               write0Val,
    input  ghtPkg::ghtIndex_t write0Index,
    input  wire               write0Wen,
    input  wire               write1Val,
    input  ghtPkg::ghtIndex_t write1Index,
    input  wire               write1Wen,
    output logic              predTaken
);
    import ghtPkg::*;

    rowAddr_t              rdRow;
    bitSel_t               rdBitSel;
    logic [NUM_BANKS-1:0]  bankBits;
    logic                  clearing;
    rowAddr_t              clearRow;

    ghtBankWriteIf bankWrIf [NUM_BANKS] ();

    ghtLookup lookup (
        .clk       (clk),
        .rst       (rst),
        .readEn    (readEn),
        .ipBits    (ipBits),
        .history   (history),
        .bankBits  (bankBits),
        .rdRow     (rdRow),
        .rdBitSel  (rdBitSel),
        .predTaken (predTaken)
    );

    ghtInitSweep sweep (
        .clk      (clk),
        .rst      (rst),
        .clearing (clearing),
        .clearRow (clearRow)
    );

    ghtWriteArbiter arbiter (
        .clk         (clk),
        .rst         (rst),
        .write0Val   (write0Val),
        .write0Index (write0Index),
        .write0Wen   (write0Wen),
        .write1Val   (write1Val),
        .write1Index (write1Index),
        .write1Wen   (write1Wen),
        .clearing    (clearing),
        .clearRow    (clearRow),
        .bankWr      (bankWrIf)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : banks
        ghtBank bank (
            .clk      (clk),
            .wr       (bankWrIf[b]),
            .rdRow    (rdRow),
            .rdBitSel (rdBitSel),
            .rdBit    (bankBits[b])
        );
    end

endmodule

`default_nettype wire

// File: dv/ghtTb.sv
// Global history table testbench.
// Drives lookups and dual-port updates with LFSR stimulus, keeps its own
// table, save buffer and index model, and compares the prediction and
// the registered lookup index every cycle after the clear sweep.

`default_nettype none
`timescale 1ns/1ps

module ghtTb;
    import ghtPkg::*;

    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      rst;
    logic      readEn;
    ghtIndex_t ipBits;
    ghtIndex_t history;
    logic      write0Val;
    ghtIndex_t write0Index;
    logic      write0Wen;
    logic      write1Val;
    ghtIndex_t write1Index;
    logic      write1Wen;
    logic      predTaken;

    logic [31:0] lfsrState = 32'h5373_eb49;
    bit          refTable [65536];
    ghtIndex_t   refIdx;
    ghtIndex_t   bufIdx;
    bit          bufVal;
    bit          bufFull;
    ghtIndex_t   sweepWrites [$];
    int          sweepCnt;
    int          errors;
    int          checks;
    int          cycles;

    ght UUT (
        .clk         (clk),
        .rst         (rst),
        .readEn      (readEn),
        .ipBits      (ipBits),
        .history     (history),
        .write0Val   (write0Val),
        .write0Index (write0Index),
        .write0Wen   (write0Wen),
        .write1Val   (write1Val),
        .write1Index (write1Index),
        .write1Wen   (write1Wen),
        .predTaken   (predTaken)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic [2:0] bankNum(ghtIndex_t idx);
        return {idx[7], idx[6], idx[0]};
    endfunction

    function automatic logic predictFor(ghtIndex_t idx);
        return refTable[idx];
    endfunction

    // buffer first, then write0, then write1; write1 wins the buffer
    task automatic applyUpdates;
        bit ok0;
        bit ok1;
        ok0 = write0Wen && !(bufFull && bankNum(write0Index) == bankNum(bufIdx));
        ok1 = write1Wen && !(bufFull && bankNum(write1Index) == bankNum(bufIdx))
              && !(write0Wen && bankNum(write1Index) == bankNum(write0Index));
        if (bufFull) refTable[bufIdx] = bufVal;
        if (ok0) refTable[write0Index] = write0Val;
        if (ok1) refTable[write1Index] = write1Val;
        bufFull = 1'b0;
        if (write1Wen && !ok1) begin
            bufFull = 1'b1;
            bufIdx  = write1Index;
            bufVal  = write1Val;
        end else if (write0Wen && !ok0) begin
            bufFull = 1'b1;
            bufIdx  = write0Index;
            bufVal  = write0Val;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            sweepCnt = 0;
            bufFull  = 1'b0;
            refIdx   = '0;
        end else begin
            if (readEn) refIdx = ipBits ^ history;
            if (sweepCnt < ROWS_PER_BANK) begin
                sweepCnt++;
                bufFull = 1'b0;
            end else begin
                applyUpdates();
            end
        end
    end

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycles);
        end
    endtask

    task automatic checkIndex(string name, ghtIndex_t got, ghtIndex_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycles);
        end
    endtask

    // mid-cycle compare, writes of the last edge have landed
    always @(negedge clk) begin
        if (!rst && sweepCnt >= ROWS_PER_BANK) begin
            checks++;
            checkBit("predTaken", predTaken, predictFor(refIdx));
            checkIndex("lookup.idxReg", UUT.lookup.idxReg, refIdx);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic nextCycle;
        @(posedge clk);
        #1;
    endtask

    task automatic lookupOf(ghtIndex_t idx);
        readEn  = 1'b1;
        ipBits  = ghtIndex_t'(randBits(16));
        history = ipBits ^ idx;
    endtask

    initial begin
        ghtIndex_t target;
        rst = 1'b1;
        readEn = 1'b0;
        ipBits = '0;
        history = '0;
        write0Val = 1'b0;
        write0Index = '0;
        write0Wen = 1'b0;
        write1Val = 1'b0;
        write1Index = '0;
        write1Wen = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // updates during the sweep must vanish
        repeat (ROWS_PER_BANK) begin
            write0Wen = 1'b1;
            write0Val = 1'b1;
            write0Index = ghtIndex_t'(randBits(16));
            write1Wen = 1'b1;
            write1Val = 1'b1;
            write1Index = ghtIndex_t'(randBits(16));
            sweepWrites.push_back(write0Index);
            sweepWrites.push_back(write1Index);
            lookupOf(ghtIndex_t'(randBits(16)));
            nextCycle();
        end
        write0Wen = 1'b0;
        write1Wen = 1'b0;

        // indices hit during the sweep read back as not-taken
        foreach (sweepWrites[i]) begin
            lookupOf(sweepWrites[i]);
            nextCycle();
        end

        // single writes then lookup of the same index
        for (int i = 0; i < 20; i++) begin
            target = ghtIndex_t'(randBits(16));
            readEn = 1'b0;
            if (i % 2 == 0) begin
                write0Wen = 1'b1;
                write0Index = target;
                write0Val = 1'(randBits(1));
            end else begin
                write1Wen = 1'b1;
                write1Index = target;
                write1Val = 1'(randBits(1));
            end
            nextCycle();
            write0Wen = 1'b0;
            write1Wen = 1'b0;
            lookupOf(target);
            nextCycle();
        end

        // aliasing pairs, then neighbours in other banks
        target = ghtIndex_t'(randBits(16));
        write0Wen = 1'b1;
        write0Index = target;
        write0Val = 1'b1;
        nextCycle();
        write0Wen = 1'b0;
        repeat (6) begin
            lookupOf(target);
            nextCycle();
        end
        for (int b = 0; b < INDEX_BITS; b++) begin
            if (b == 0 || b == 6 || b == 7) begin
                lookupOf(target ^ (ghtIndex_t'(1) << b));
                nextCycle();
            end
        end

        // dual updates, same bank often
        repeat (200) begin
            write0Index = ghtIndex_t'(randBits(16));
            write0Val = 1'(randBits(1));
            write0Wen = (randBits(2) != 0);
            if (randBits(1)) begin
                write1Index = {8'(randBits(8)), write0Index[7:0]};
            end else begin
                write1Index = ghtIndex_t'(randBits(16));
            end
            write1Val = 1'(randBits(1));
            write1Wen = (randBits(2) != 0);
            if (randBits(1)) lookupOf(write0Index);
            else lookupOf(write1Index);
            readEn = 1'(randBits(1));
            nextCycle();
        end

        // held index keeps tracking writes with readEn low
        target = ghtIndex_t'(randBits(16));
        write0Wen = 1'b0;
        write1Wen = 1'b0;
        lookupOf(target);
        nextCycle();
        readEn = 1'b0;
        for (int i = 0; i < 10; i++) begin
            ipBits = ghtIndex_t'(randBits(16));
            write0Wen = 1'b1;
            write0Index = target;
            write0Val = i[0];
            nextCycle();
        end
        write0Wen = 1'b0;
        repeat (4) nextCycle();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ght.f
source/ghtPkg.sv
source/ghtBankWriteIf.sv
source/ghtBank.sv
source/ghtLookup.sv
source/ghtInitSweep.sv
source/ghtWriteArbiter.sv
source/ght.sv
dv/ghtTb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= ghtTb
RTL_TOP    ?= ght
FILELIST   ?= ght.f
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
